// ==== src/lsab_pkg.sv ====
`default_nettype none

package lsab_pkg;

	// Buffer geometry
	localparam int lsab_words   = 64;  // Depth in words
	localparam int lsab_addr_w  = 6;   // Pointer width
	localparam int lsab_level_w = 7;   // Level counts 0 to 64

	// Slot ring, one turn per client
	localparam int slot_w = 2;
	localparam logic [slot_w-1:0] rx_slot    = 2'd0;  // Receive write turn
	localparam logic [slot_w-1:0] drain_slot = 2'd2;  // Drain pop turn

	// Kind bit, same position in both status views
	localparam logic status_kind_rx  = 1'b0;
	localparam logic status_kind_err = 1'b1;

	typedef struct packed {
		logic                    kind;      // status_kind_rx
		logic                    frame_ok;  // Validity flag from the MAC
		logic [22:0]             spare;
		logic [lsab_level_w-1:0] words;     // Words in the frame
	} status_rx_t;

	// Collision report
	typedef struct packed {
		logic                    kind;        // status_kind_err
		logic                    drain_busy;  // Earlier drain still running
		logic [22:0]             spare;
		logic [lsab_level_w-1:0] level;       // Buffer level when the collision hit
	} status_err_t;

	// One status word, read by the CPU in either view
	typedef union packed {
		status_rx_t  rx;
		status_err_t err;
	} lsab_status_u;

endpackage

`default_nettype wire

// ==== src/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

	// Word width on the MAC receive side
	localparam int mac_data_w = 32;

	// Stale words thrown away after a collision acknowledge
	// Limit is reached when counter bit 6 sets
	localparam int drain_words = 64;

	// Drain counter, top bit parks the drain
	localparam int drain_cnt_w = 8;

endpackage

`default_nettype wire

// ==== src/rx_write_adaptor.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_write_adaptor
	import lsab_pkg::*, mac_pkg::*;
(
	input  wire                       CLK,
	input  wire                       RST,
	input  wire  [slot_w-1:0]         lsab_turn,
	input  wire  [mac_data_w-1:0]     data_from_mac,
	input  wire                       write_in,        // Level, one word per rising edge
	input  wire                       new_pckt,        // Rises once per frame end
	input  wire                       new_pckt_valid,
	output logic                      fifo_wr,
	output logic [mac_data_w-1:0]     fifo_wdata,
	output logic                      fifo_wlast,
	output logic                      frame_done,
	output logic                      frame_ok,
	output logic [lsab_level_w-1:0]   frame_words
);

	logic                    write_in_r;     // Strobe synchronizer
	logic                    write_in_prev;  // Edge stage
	logic                    new_pckt_r;
	logic                    new_pckt_prev;
	logic                    valid_r;        // Validity, sampled with new_pckt
	logic                    write_edge;
	logic                    end_edge;
	logic                    my_turn;

	// The MAC signals frame end only after its last write, so the newest word
	// stays in the holder until it is known whether it closes the frame
	logic [mac_data_w-1:0]   holder;
	logic                    holder_full;
	logic [mac_data_w-1:0]   out_word;       // Previous word, waiting for an rx turn
	logic                    out_valid;
	logic                    end_pend;       // Frame end seen, report not sent yet
	logic                    ok_r;
	logic [lsab_level_w-1:0] word_cnt;       // Write edges in the current frame

	assign my_turn    = lsab_turn == rx_slot;
	assign write_edge = write_in_r && !write_in_prev;
	assign end_edge   = new_pckt_r && !new_pckt_prev;

	// Plain words go first, the frame end takes the next free rx turn
	assign fifo_wr     = my_turn && (out_valid || (end_pend && holder_full));
	assign fifo_wdata  = out_valid ? out_word : holder;
	assign fifo_wlast  = !out_valid;  // Holder word only leaves at frame end
	assign frame_done  = my_turn && !out_valid && end_pend;  // Pulses even with no held word
	assign frame_ok    = ok_r;
	assign frame_words = word_cnt;

	always_ff @(posedge CLK)
		if (!RST)
		begin
			write_in_r    <= 1'b0;
			write_in_prev <= 1'b0;
			new_pckt_r    <= 1'b0;
			new_pckt_prev <= 1'b0;
			valid_r       <= 1'b0;
			holder_full   <= 1'b0;
			out_valid     <= 1'b0;
			end_pend      <= 1'b0;
			ok_r          <= 1'b0;
			word_cnt      <= '0;
		end
		else
		begin
			write_in_r    <= write_in;
			write_in_prev <= write_in_r;
			new_pckt_r    <= new_pckt;
			new_pckt_prev <= new_pckt_r;
			valid_r       <= new_pckt_valid;

			if (end_edge)
			begin
				end_pend <= 1'b1;
				ok_r     <= valid_r;  // Validity belongs to the frame-end edge
			end
			else if (frame_done)
				end_pend <= 1'b0;

			// New word pushes the held one out, unless frame end just took it
			if (write_edge)
			begin
				out_valid   <= holder_full && !frame_done;
				holder_full <= 1'b1;
			end
			else
			begin
				if (my_turn)
					out_valid <= 1'b0;  // Written this turn
				if (frame_done)
					holder_full <= 1'b0;
			end

			// Count advances even if the FIFO drops the word
			if (frame_done)
				word_cnt <= write_edge ? lsab_level_w'(1) : '0;
			else if (write_edge)
				word_cnt <= word_cnt + 1'b1;
		end

	// Data moves only on a write edge, while the MAC still holds it stable
	always_ff @(posedge CLK)
		if (write_edge)
		begin
			out_word <= holder;
			holder   <= data_from_mac;
		end

endmodule

`default_nettype wire

// ==== src/collision_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module collision_drain
	import lsab_pkg::*, mac_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire  [slot_w-1:0]       lsab_turn,
	input  wire                     collision,
	input  wire  [lsab_level_w-1:0] level,
	input  wire                     err_ack,     // One-cycle pulse from the bus port
	output logic                    err_askfor,  // Held until the CPU acknowledges
	output logic                    drain_pop,
	output logic                    drain_busy
);

	logic                   coll_r;
	logic                   coll_prev;
	logic                   coll_edge;
	logic                   my_turn;
	logic [drain_cnt_w-1:0] drain_cnt;  // Pops since acknowledge, top bit parks
	logic                   limit_hit;  // drain_words popped
	logic                   parked;
	logic                   buf_empty;

	assign my_turn   = lsab_turn == drain_slot;
	assign coll_edge = coll_r && !coll_prev;
	assign limit_hit = drain_cnt[$clog2(drain_words)];
	assign parked    = drain_cnt[drain_cnt_w-1];
	assign buf_empty = level == '0;

	assign drain_busy = !parked;
	// Only on the drain turn, so never together with a CPU pop
	assign drain_pop  = my_turn && !parked && !limit_hit && !buf_empty;

	always_ff @(posedge CLK)
		if (!RST)
		begin
			coll_r     <= 1'b0;
			coll_prev  <= 1'b0;
			err_askfor <= 1'b0;
			drain_cnt  <= {1'b1, {(drain_cnt_w-1){1'b0}}};  // Parked out of reset
		end
		else
		begin
			coll_r    <= collision;
			coll_prev <= coll_r;

			if (coll_edge)
				err_askfor <= 1'b1;
			else if (err_ack)
				err_askfor <= 1'b0;

			// Acknowledge restarts the drain
			if (err_askfor && err_ack)
				drain_cnt <= '0;
			else if (!parked)
			begin
				if (limit_hit || buf_empty)
					drain_cnt[drain_cnt_w-1] <= 1'b1;  // Done, wait for the next acknowledge
				else if (drain_pop)
					drain_cnt <= drain_cnt + 1'b1;
			end
		end

endmodule

`default_nettype wire

// ==== src/lsab_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsab_fifo
	import lsab_pkg::*, mac_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     wr,         // From the rx adaptor, rx turn only
	input  wire  [mac_data_w-1:0]   wdata,
	input  wire                     wlast,
	input  wire                     pop,        // Drain or CPU pop, never both
	output logic [slot_w-1:0]       lsab_turn,  // Free-running slot ring
	output logic [mac_data_w-1:0]   rdata,      // Head word, no read latency
	output logic                    rlast,
	output logic [lsab_level_w-1:0] level
);

	// Entry is the data word with the last-word flag on top
	logic [mac_data_w:0]    mem [lsab_words];
	logic [lsab_addr_w-1:0] wr_ptr;
	logic [lsab_addr_w-1:0] rd_ptr;
	logic                   full;
	logic                   empty;
	logic                   do_wr;
	logic                   do_pop;

	assign full   = level == lsab_level_w'(lsab_words);
	assign empty  = level == '0;
	assign do_wr  = wr && !full;    // Word is lost when full
	assign do_pop = pop && !empty;

	assign {rlast, rdata} = mem[rd_ptr];

	// Slot ring, 0 to 3 and wrap
	always_ff @(posedge CLK)
		if (!RST)
			lsab_turn <= '0;
		else
			lsab_turn <= lsab_turn + 1'b1;

	always_ff @(posedge CLK)
		if (!RST)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at lsab_words
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_wr, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;  // Both or neither
			endcase
		end

	// Storage
	always_ff @(posedge CLK)
		if (do_wr)
			mem[wr_ptr] <= {wlast, wdata};

endmodule

`default_nettype wire

// ==== src/lsab_wb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsab_wb_port
	import lsab_pkg::*, mac_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     wb_cyc,
	input  wire                     wb_stb,
	input  wire                     wb_we,
	input  wire  [3:0]              wb_adr,      // Byte offset
	input  wire  [mac_data_w-1:0]   wb_dat_w,
	input  wire  [slot_w-1:0]       lsab_turn,
	input  wire  [mac_data_w-1:0]   rdata,
	input  wire  [lsab_level_w-1:0] level,
	input  wire                     frame_done,
	input  wire                     frame_ok,
	input  wire  [lsab_level_w-1:0] frame_words,
	input  wire                     err_askfor,
	input  wire                     drain_busy,
	output logic [mac_data_w-1:0]   wb_dat_r,
	output logic                    wb_ack,
	output logic                    irq,
	output logic                    cpu_pop,
	output logic                    err_ack
);

	localparam logic [3:0] adr_data    = 4'h0;  // Read pops one word
	localparam logic [3:0] adr_status  = 4'h4;  // Read clears irq
	localparam logic [3:0] adr_err_ack = 4'h8;  // Any write acknowledges
	localparam logic [3:0] adr_level   = 4'hC;

	lsab_status_u          status_q;     // Latest event only
	logic                  askfor_prev;
	logic                  err_rise;
	logic                  req;
	logic                  rd_data;
	logic                  go;           // Cycle completes with ack on the next clock
	logic [mac_data_w-1:0] rd_word;

	assign req      = wb_cyc && wb_stb && !wb_ack;  // Master drops stb after ack
	assign rd_data  = !wb_we && wb_adr == adr_data;
	assign go       = req && (!rd_data || lsab_turn != drain_slot);  // Data reads skip drain turn
	assign cpu_pop  = go && rd_data && level != '0;
	assign err_rise = err_askfor && !askfor_prev;

	always_comb
		case (wb_adr)
			adr_data:   rd_word = (level != '0) ? rdata : '0;  // Empty reads 0
			adr_status: rd_word = status_q;
			adr_level:  rd_word = mac_data_w'(level);
			default:    rd_word = '0;
		endcase

	always_ff @(posedge CLK)
		if (!RST)
		begin
			wb_ack      <= 1'b0;
			err_ack     <= 1'b0;
			irq         <= 1'b0;
			askfor_prev <= 1'b0;
			status_q    <= '0;
		end
		else
		begin
			wb_ack      <= go;
			err_ack     <= go && wb_we && wb_adr == adr_err_ack;
			askfor_prev <= err_askfor;

			// Collision report takes the word if both land together
			if (err_rise)
			begin
				status_q.err.kind       <= status_kind_err;
				status_q.err.drain_busy <= drain_busy;
				status_q.err.spare      <= '0;
				status_q.err.level      <= level;
			end
			else if (frame_done)
			begin
				status_q.rx.kind     <= status_kind_rx;
				status_q.rx.frame_ok <= frame_ok;
				status_q.rx.spare    <= '0;
				status_q.rx.words    <= frame_words;
			end

			if (err_rise || frame_done)
				irq <= 1'b1;  // New event wins over a status read
			else if (go && !wb_we && wb_adr == adr_status)
				irq <= 1'b0;
		end

	// Read data is sampled with the pop
	always_ff @(posedge CLK)
		if (go)
			wb_dat_r <= rd_word;

endmodule

`default_nettype wire

// ==== src/mac_lsab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_lsab_top
	import lsab_pkg::*, mac_pkg::*;
(
	input  wire                    CLK,
	input  wire                    RST,
	// MAC receive side
	input  wire  [mac_data_w-1:0]  data_from_mac,
	input  wire                    write_in,
	input  wire                    new_pckt,
	input  wire                    new_pckt_valid,
	input  wire                    collision,
	// Wishbone classic slave
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire  [3:0]             wb_adr,
	input  wire  [mac_data_w-1:0]  wb_dat_w,
	output wire  [mac_data_w-1:0]  wb_dat_r,
	output wire                    wb_ack,
	output wire                    irq
);

	wire [slot_w-1:0]       lsab_turn;
	wire                    fifo_wr;
	wire [mac_data_w-1:0]   fifo_wdata;
	wire                    fifo_wlast;
	wire                    frame_done;
	wire                    frame_ok;
	wire [lsab_level_w-1:0] frame_words;
	wire                    err_askfor;
	wire                    err_ack;
	wire                    drain_pop;
	wire                    drain_busy;
	wire                    cpu_pop;
	wire                    lsab_pop;
	wire [mac_data_w-1:0]   rdata;
	wire [lsab_level_w-1:0] level;

	// Slots keep the two poppers apart
	assign lsab_pop = drain_pop || cpu_pop;

	rx_write_adaptor rx0 (
		.CLK(CLK), .RST(RST), .lsab_turn(lsab_turn),
		.data_from_mac(data_from_mac), .write_in(write_in),
		.new_pckt(new_pckt), .new_pckt_valid(new_pckt_valid),
		.fifo_wr(fifo_wr), .fifo_wdata(fifo_wdata), .fifo_wlast(fifo_wlast),
		.frame_done(frame_done), .frame_ok(frame_ok), .frame_words(frame_words)
	);

	collision_drain coll0 (
		.CLK(CLK), .RST(RST), .lsab_turn(lsab_turn), .collision(collision),
		.level(level), .err_ack(err_ack), .err_askfor(err_askfor),
		.drain_pop(drain_pop), .drain_busy(drain_busy)
	);

	// Last-word flag travels with the data, the classic port has no use for it
	lsab_fifo fifo0 (
		.CLK(CLK), .RST(RST), .wr(fifo_wr), .wdata(fifo_wdata), .wlast(fifo_wlast),
		.pop(lsab_pop), .lsab_turn(lsab_turn), .rdata(rdata), .rlast(), .level(level)
	);

	lsab_wb_port wb0 (
		.CLK(CLK), .RST(RST), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .lsab_turn(lsab_turn),
		.rdata(rdata), .level(level), .frame_done(frame_done),
		.frame_ok(frame_ok), .frame_words(frame_words), .err_askfor(err_askfor),
		.drain_busy(drain_busy), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.irq(irq), .cpu_pop(cpu_pop), .err_ack(err_ack)
	);

endmodule

`default_nettype wire

// ==== tb/tb_mac_lsab.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mac_lsab
	import lsab_pkg::*, mac_pkg::*;
();

	// Register map, byte offsets
	localparam logic [3:0] adr_data     = 4'h0;
	localparam logic [3:0] adr_status   = 4'h4;
	localparam logic [3:0] adr_err_ack  = 4'h8;
	localparam logic [3:0] adr_level    = 4'hC;
	localparam logic [3:0] adr_unmapped = 4'h6;
	localparam int reset_cycles = 5;
	localparam int word_gap     = 6;   // Cycles between write_in edges
	localparam int ack_limit    = 50;
	localparam int poll_limit   = 40;  // Level reads per wait
	localparam int irq_limit    = 20;
	// Run length from the words, frame ends and bus cycles of all tests
	localparam int words_sent  = 5 + 3 + 7 + 6 + 2;
	localparam int frames_sent = 6;
	localparam int bus_cycles  = 90 * 4;  // About 90 accesses of up to 4 cycles
	localparam int run_cycles  = reset_cycles + words_sent * word_gap
		+ frames_sent * (2 * word_gap + 6) + bus_cycles;
	localparam int watchdog_cycles = 2 * run_cycles;  // Margin for stalls

	logic                  CLK;
	logic                  RST;
	logic [mac_data_w-1:0] data_from_mac;
	logic                  write_in;
	logic                  new_pckt;
	logic                  new_pckt_valid;
	logic                  collision;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [3:0]            wb_adr;
	logic [mac_data_w-1:0] wb_dat_w;
	logic [mac_data_w-1:0] wb_dat_r;
	logic                  wb_ack;
	logic                  irq;
	int                    value_errs;
	int                    other_errs;
	logic [31:0]           lfsr;
	logic [mac_data_w-1:0] sent_q[$];  // Words the FIFO should deliver, oldest first

	mac_lsab_top dut0 (
		.CLK(CLK), .RST(RST), .data_from_mac(data_from_mac), .write_in(write_in),
		.new_pckt(new_pckt), .new_pckt_valid(new_pckt_valid), .collision(collision),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .irq(irq)
	);

	always #10 CLK = ~CLK;  // 20 ns period

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_rand_word(output logic [mac_data_w-1:0] w);
		w = '0;
		for (int i = 0; i < mac_data_w; i++)
		begin
			lfsr = lfsr_step(lfsr);  // One step per bit
			w = {w[mac_data_w-2:0], lfsr[0]};
		end
	endtask

	function automatic lsab_status_u rx_report(input logic ok, input logic [lsab_level_w-1:0] n);
		lsab_status_u s;
		s = '0;
		s.rx.kind = status_kind_rx;
		s.rx.frame_ok = ok;
		s.rx.words = n;
		return s;
	endfunction

	function automatic lsab_status_u err_report(input logic busy,
		input logic [lsab_level_w-1:0] lvl);
		lsab_status_u s;
		s = '0;
		s.err.kind = status_kind_err;
		s.err.drain_busy = busy;
		s.err.level = lvl;
		return s;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errs++;
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
	endtask

	task automatic check_word(input string name, input logic [mac_data_w-1:0] got,
		input logic [mac_data_w-1:0] exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_level(input string name, input logic [lsab_level_w-1:0] got,
		input logic [lsab_level_w-1:0] exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	// Kind first, then the fields of the view it selects
	task automatic check_status(input string name, input lsab_status_u got,
		input lsab_status_u exp);
		if (got.rx.kind !== exp.rx.kind)
			report_mismatch({name, ".kind"}, 32'(got.rx.kind), 32'(exp.rx.kind));
		else if (exp.rx.kind == status_kind_rx)
		begin
			if (got.rx.frame_ok !== exp.rx.frame_ok)
				report_mismatch({name, ".frame_ok"}, 32'(got.rx.frame_ok), 32'(exp.rx.frame_ok));
			if (got.rx.words !== exp.rx.words)
				report_mismatch({name, ".words"}, 32'(got.rx.words), 32'(exp.rx.words));
			if (got.rx.spare !== exp.rx.spare)
				report_mismatch({name, ".spare"}, 32'(got.rx.spare), 32'(exp.rx.spare));
		end
		else
		begin
			if (got.err.drain_busy !== exp.err.drain_busy)
				report_mismatch({name, ".drain_busy"}, 32'(got.err.drain_busy),
					32'(exp.err.drain_busy));
			if (got.err.level !== exp.err.level)
				report_mismatch({name, ".level"}, 32'(got.err.level), 32'(exp.err.level));
			if (got.err.spare !== exp.err.spare)
				report_mismatch({name, ".spare"}, 32'(got.err.spare), 32'(exp.err.spare));
		end
	endtask

	// One classic cycle, held until ack or the limit
	task automatic bus_cycle(input logic we, input logic [3:0] adr,
		input logic [mac_data_w-1:0] wdata, output logic [mac_data_w-1:0] rdata);
		int waited;
		waited = 0;
		rdata = '0;
		@(negedge CLK);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do
		begin
			@(negedge CLK);
			waited++;
		end
		while (!wb_ack && waited < ack_limit);
		if (wb_ack)
			rdata = wb_dat_r;
		else
		begin
			other_errs++;
			$display("no ack within %0d cycles at offset 0x%h", ack_limit, adr);
		end
		wb_cyc = 1'b0;  // Drop the cycle right after ack
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [mac_data_w-1:0] data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [mac_data_w-1:0] data);
		logic [mac_data_w-1:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wait_level(input logic [lsab_level_w-1:0] target);
		logic [mac_data_w-1:0] d;
		int polls;
		polls = 0;
		do
		begin
			wb_read(adr_level, d);
			polls++;
		end
		while (d[lsab_level_w-1:0] != target && polls < poll_limit);
		if (d[lsab_level_w-1:0] != target)
		begin
			other_errs++;
			$display("level stuck at %0d, expected %0d after %0d reads",
				d[lsab_level_w-1:0], target, polls);
		end
	endtask

	task automatic wait_irq();
		int waited;
		waited = 0;
		while (!irq && waited < irq_limit)
		begin
			@(negedge CLK);
			waited++;
		end
		if (!irq)
		begin
			other_errs++;
			$display("irq did not rise within %0d cycles", irq_limit);
		end
	endtask

	task automatic expect_level(input logic [lsab_level_w-1:0] exp);
		logic [mac_data_w-1:0] d;
		wb_read(adr_level, d);
		check_level("level", d[lsab_level_w-1:0], exp);
	endtask

	task automatic expect_status(input lsab_status_u exp);
		logic [mac_data_w-1:0] d;
		wb_read(adr_status, d);
		check_status("status", d, exp);
		check_bit("irq", irq, 1'b0);  // Status read clears it
	endtask

	// MAC model, one rising write_in edge per word, frame end afterwards
	task automatic mac_send_frame(input int n, input logic ok);
		logic [mac_data_w-1:0] w;
		for (int i = 0; i < n; i++)
		begin
			next_rand_word(w);
			sent_q.push_back(w);
			@(negedge CLK);
			data_from_mac = w;  // Stable until the next word
			write_in = 1'b1;
			repeat (word_gap / 2) @(negedge CLK);
			write_in = 1'b0;
			repeat (word_gap - word_gap / 2 - 1) @(negedge CLK);
		end
		repeat (word_gap) @(negedge CLK);
		new_pckt = 1'b1;
		new_pckt_valid = ok;
		repeat (4) @(negedge CLK);
		new_pckt = 1'b0;
		new_pckt_valid = 1'b0;
		repeat (word_gap) @(negedge CLK);
	endtask

	task automatic pop_and_check(input int n);
		logic [mac_data_w-1:0] d;
		for (int i = 0; i < n; i++)
		begin
			wb_read(adr_data, d);
			check_word("pop data", d, sent_q.size() > 0 ? sent_q.pop_front() : '0);
		end
	endtask

	task automatic test_reset_state();
		logic [mac_data_w-1:0] d;
		check_bit("irq", irq, 1'b0);
		expect_status(rx_report(1'b0, 0));
		expect_level(0);
		wb_read(adr_data, d);
		check_word("empty pop", d, '0);
		wb_read(adr_unmapped, d);
		check_word("unmapped read", d, '0);
	endtask

	task automatic test_single_frame();
		mac_send_frame(5, 1'b1);
		wait_level(5);
		check_bit("irq", irq, 1'b1);
		expect_status(rx_report(1'b1, 5));
		expect_level(5);
		pop_and_check(5);
		expect_level(0);
	endtask

	task automatic test_invalid_frame();
		mac_send_frame(3, 1'b0);
		wait_level(3);
		expect_status(rx_report(1'b0, 3));  // Data still kept
		pop_and_check(3);
		expect_level(0);
	endtask

	task automatic test_back_to_back();
		mac_send_frame(3, 1'b1);
		mac_send_frame(4, 1'b1);
		wait_level(7);
		expect_status(rx_report(1'b1, 4));  // Latest frame only
		pop_and_check(7);
		expect_level(0);
	endtask

	task automatic test_collision_drain();
		mac_send_frame(6, 1'b1);
		wait_level(6);
		expect_status(rx_report(1'b1, 6));
		@(negedge CLK);
		collision = 1'b1;
		repeat (3) @(negedge CLK);
		collision = 1'b0;
		wait_irq();
		check_bit("irq", irq, 1'b1);
		expect_status(err_report(1'b0, 6));  // No drain before the acknowledge
		expect_level(6);
		wb_write(adr_err_ack, 32'h1);
		wait_level(0);
		sent_q.delete();  // Drained words never reach the CPU
		mac_send_frame(2, 1'b1);
		wait_level(2);
		expect_status(rx_report(1'b1, 2));
		pop_and_check(2);
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge CLK);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		$display("test failed");
		$finish;
	end

	initial
	begin
		CLK = 1'b0;
		RST = 1'b0;
		data_from_mac = '0;
		write_in = 1'b0;
		new_pckt = 1'b0;
		new_pckt_valid = 1'b0;
		collision = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		value_errs = 0;
		other_errs = 0;
		lfsr = 32'h178f_4472;
		repeat (reset_cycles) @(negedge CLK);
		RST = 1'b1;
		test_reset_state();
		test_single_frame();
		test_invalid_frame();
		test_back_to_back();
		test_collision_drain();
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mac_lsab_top.f ====
src/lsab_pkg.sv
src/mac_pkg.sv
src/rx_write_adaptor.sv
src/collision_drain.sv
src/lsab_fifo.sv
src/lsab_wb_port.sv
src/mac_lsab_top.sv
tb/tb_mac_lsab.sv

// ==== Makefile ====
TOP = tb_mac_lsab

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f mac_lsab_top.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir
